// ==== rtl/uartTx_macros.svh ====
// FIFO depth, pointer width and bit timing for the UART transmitter
`ifndef UART_TX_MACROS_SVH
`define UART_TX_MACROS_SVH

// ----------------------------------------------------------------------
// transmit FIFO
// ----------------------------------------------------------------------
// number of RAM entries, one of them always stays empty
`define UART_FIFO_DEPTH 16
// read and write pointer width, log2 of the depth
`define UART_PTR_WIDTH 4

// ----------------------------------------------------------------------
// serial line timing
// ----------------------------------------------------------------------
// clock cycles per serial bit
// kept short for simulation
`define UART_CLKS_PER_BIT 4

`endif

// ==== rtl/uartTxPkg.sv ====
// transmit word struct and serializer state type for the UART transmitter
package uartTxPkg;

    // ----------------------------------------------------------------------
    // transmit word, FIFO payload and serializer load word
    // ----------------------------------------------------------------------
    typedef struct packed {
        // byte sent LSB first
        logic [7:0] data;
        // adds an even parity bit after the data
        logic       parityEn;
    } txWord_t;

    // ----------------------------------------------------------------------
    // serializer frame phase
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        sIdle,
        sStart,
        sData,
        sParity,
        sStop
    } serState_t;

endpackage

// ==== rtl/fifoRam.sv ====
// dual-port FIFO storage with synchronous write and registered read
`timescale 1ns/1ps
`include "uartTx_macros.svh"

module fifoRam #(
    parameter type payload_t = uartTxPkg::txWord_t,
    parameter int  depth     = `UART_FIFO_DEPTH
) (
    input  logic                     iClk,
    // write port
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] wrAddr,
    input  payload_t                 wrData,
    // read port
    input  logic [$clog2(depth)-1:0] rdAddr,
    output payload_t                 rdData
);

    // storage array, contents undefined until written
    payload_t mem [depth];

    // write side
    always_ff @(posedge iClk)
    begin
        if (we)
        begin
            mem[wrAddr] <= wrData;
        end
    end

    // read side, one register stage
    // address is sampled every cycle, controller decides validity
    always_ff @(posedge iClk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

// ==== rtl/fifoController.sv ====
// FIFO controller with pointers, full and empty levels and read-valid pulse
`timescale 1ns/1ps
`include "uartTx_macros.svh"

module fifoController #(
    parameter type payload_t = uartTxPkg::txWord_t,
    parameter int  depth     = `UART_FIFO_DEPTH
) (
    input  logic     iClk,
    input  logic     rstN,
    // write side
    input  logic     wr,
    input  payload_t wrWord,
    output logic     full,
    // read side
    input  logic     rd,
    output payload_t rdWord,
    output logic     rdValid,
    output logic     empty
);

    localparam int ptrWidth = `UART_PTR_WIDTH;

    // pointer width has to cover the RAM address
    if ($clog2(depth) != ptrWidth)
    begin : gPtrCheck
        $error("FIFO pointer width does not match depth");
    end

    // ----------------------------------------------------------------------
    // pointers
    // ----------------------------------------------------------------------
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    // read pointer one cycle late, a change marks a new word
    logic [ptrWidth-1:0] rdPtrDly;
    logic [ptrWidth-1:0] wrPtrNext;
    logic                wrAcc;
    logic                rdAcc;
    payload_t            ramData;

    // levels straight from the pointer registers
    assign wrPtrNext = ptrWidth'(wrPtr + 1'b1);
    assign full      = (wrPtrNext == rdPtr);
    assign empty     = (wrPtr == rdPtr);

    // strobes only count when the level allows them
    assign wrAcc = wr && !full;
    assign rdAcc = rd && !empty;

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            rdPtrDly <= '0;
        end
        else
        begin
            if (wrAcc)
            begin
                wrPtr <= wrPtrNext;
            end
            if (rdAcc)
            begin
                rdPtr <= ptrWidth'(rdPtr + 1'b1);
            end
            rdPtrDly <= rdPtr;
        end
    end

    // ----------------------------------------------------------------------
    // storage and output stage
    // ----------------------------------------------------------------------
    fifoRam #(
        .payload_t (payload_t),
        .depth     (depth)
    ) ram0 (
        .iClk   (iClk),
        .we     (wrAcc),
        .wrAddr (wrPtr),
        .wrData (wrWord),
        .rdAddr (rdPtr),
        .rdData (ramData)
    );

    // second register, word and pulse line up two cycles after rd
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            rdValid <= 1'b0;
        end
        else
        begin
            rdValid <= (rdPtr != rdPtrDly);
        end
    end

    always_ff @(posedge iClk)
    begin
        rdWord <= ramData;
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // host must respect full
    aNoWrWhenFull: assert property (@(posedge iClk) disable iff (!rstN)
        wr |-> !full);

    // reader must respect empty
    aNoRdWhenEmpty: assert property (@(posedge iClk) disable iff (!rstN)
        rd |-> !empty);

    // back-to-back pulses need back-to-back accepted reads
    aRdValidPair: assert property (@(posedge iClk) disable iff (!rstN)
        rdValid && $past(rdValid) |-> $past(rdAcc, 2) && $past(rdAcc, 3));

endmodule

// ==== rtl/txScheduler.sv ====
// scheduler that pops the FIFO into the serializer one word at a time
`timescale 1ns/1ps

module txScheduler (
    input  logic               iClk,
    input  logic               rstN,
    // FIFO read side
    input  logic               empty,
    output logic               rd,
    input  logic               rdValid,
    input  uartTxPkg::txWord_t rdWord,
    // serializer side
    output logic               load,
    output uartTxPkg::txWord_t loadWord,
    input  logic               serIdle,
    // whole transmitter quiet
    output logic               txIdle
);

    // one read in flight, set on rd and cleared on load
    logic pending;

    // ----------------------------------------------------------------------
    // read request
    // ----------------------------------------------------------------------
    // only ask while the serializer is free and nothing is on its way
    // serIdle drops on the load edge, which holds off the next rd
    // until the frame has finished
    assign rd = serIdle && !empty && !pending;

    // ----------------------------------------------------------------------
    // hand-over
    // ----------------------------------------------------------------------
    // word goes to the serializer in the cycle it arrives
    assign load     = rdValid && pending;
    assign loadWord = rdWord;

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            pending <= 1'b0;
        end
        else if (rd)
        begin
            pending <= 1'b1;
        end
        else if (load)
        begin
            pending <= 1'b0;
        end
    end

    // quiet only with nothing queued, fetched or sending
    assign txIdle = empty && !pending && serIdle;

endmodule

// ==== rtl/txSerializer.sv ====
// frame builder and bit timer driving the asynchronous serial line
`timescale 1ns/1ps
`include "uartTx_macros.svh"

module txSerializer (
    input  logic               iClk,
    input  logic               rstN,
    input  logic               load,
    input  uartTxPkg::txWord_t loadWord,
    output logic               serIdle,
    output logic               txLine
);

    localparam int clksPerBit = `UART_CLKS_PER_BIT;
    localparam int cntWidth   = (clksPerBit > 1) ? $clog2(clksPerBit) : 1;
    // shortest frame, start, eight data bits and stop
    localparam int frameMin   = 10 * clksPerBit;

    uartTxPkg::serState_t state;
    logic [cntWidth-1:0]  clkCnt;
    logic [2:0]           bitIdx;
    logic                 bitEnd;

    // frame payload captured at load
    logic [7:0]           dataReg;
    logic                 parityEn;
    logic                 parityBit;

    assign serIdle = (state == uartTxPkg::sIdle);
    assign bitEnd  = (clkCnt == cntWidth'(clksPerBit - 1));

    // payload registers, even parity precomputed
    always_ff @(posedge iClk)
    begin
        if (load)
        begin
            dataReg   <= loadWord.data;
            parityEn  <= loadWord.parityEn;
            parityBit <= ^loadWord.data;
        end
    end

    // ----------------------------------------------------------------------
    // frame FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state  <= uartTxPkg::sIdle;
            clkCnt <= '0;
            bitIdx <= '0;
            txLine <= 1'b1;
        end
        else if (state == uartTxPkg::sIdle)
        begin
            // start bit goes out right from the load edge
            if (load)
            begin
                state  <= uartTxPkg::sStart;
                clkCnt <= '0;
                txLine <= 1'b0;
            end
        end
        else if (!bitEnd)
        begin
            clkCnt <= cntWidth'(clkCnt + 1'b1);
        end
        else
        begin
            clkCnt <= '0;
            case (state)
                uartTxPkg::sStart:
                begin
                    state  <= uartTxPkg::sData;
                    bitIdx <= '0;
                    txLine <= dataReg[0];
                end
                uartTxPkg::sData:
                begin
                    if (bitIdx == 3'd7)
                    begin
                        // last data bit done
                        state  <= parityEn ? uartTxPkg::sParity : uartTxPkg::sStop;
                        txLine <= parityEn ? parityBit : 1'b1;
                    end
                    else
                    begin
                        bitIdx <= 3'(bitIdx + 1'b1);
                        txLine <= dataReg[3'(bitIdx + 1'b1)];
                    end
                end
                uartTxPkg::sParity:
                begin
                    state  <= uartTxPkg::sStop;
                    txLine <= 1'b1;
                end
                default:
                begin
                    // end of stop bit, line stays high
                    state  <= uartTxPkg::sIdle;
                    txLine <= 1'b1;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // scheduler may only load a free serializer
    aLoadWhenIdle: assert property (@(posedge iClk) disable iff (!rstN)
        load |-> serIdle);

    // a frame keeps the serializer busy for at least ten bit periods
    aFrameLength: assert property (@(posedge iClk) disable iff (!rstN)
        load |=> (!serIdle) [* frameMin]);

endmodule

// ==== rtl/uartTx.sv ====
// top level of the buffered UART transmitter
`timescale 1ns/1ps

module uartTx (
    input  logic               iClk,
    input  logic               rstN,
    // host write side
    input  uartTxPkg::txWord_t wrWord,
    input  logic               wr,
    output logic               full,
    // serial side
    output logic               txLine,
    output logic               txIdle
);

    // FIFO to scheduler
    logic               empty;
    logic               rd;
    logic               rdValid;
    uartTxPkg::txWord_t rdWord;

    // scheduler to serializer
    logic               load;
    uartTxPkg::txWord_t loadWord;
    logic               serIdle;

    fifoController #(
        .payload_t (uartTxPkg::txWord_t)
    ) fifo0 (
        .iClk    (iClk),
        .rstN    (rstN),
        .wr      (wr),
        .wrWord  (wrWord),
        .full    (full),
        .rd      (rd),
        .rdWord  (rdWord),
        .rdValid (rdValid),
        .empty   (empty)
    );

    txScheduler sched0 (
        .iClk     (iClk),
        .rstN     (rstN),
        .empty    (empty),
        .rd       (rd),
        .rdValid  (rdValid),
        .rdWord   (rdWord),
        .load     (load),
        .loadWord (loadWord),
        .serIdle  (serIdle),
        .txIdle   (txIdle)
    );

    txSerializer ser0 (
        .iClk     (iClk),
        .rstN     (rstN),
        .load     (load),
        .loadWord (loadWord),
        .serIdle  (serIdle),
        .txLine   (txLine)
    );

endmodule

// ==== tests/uartTxTb.sv ====
// testbench for the UART transmitter with frame reference and serial-line checker
`timescale 1ns/1ps
`include "uartTx_macros.svh"

module uartTxTb;

    localparam int clksPerBit = `UART_CLKS_PER_BIT;
    // inputs change this long after the rising edge
    localparam int drvDelay   = 10;
    localparam int idleLimit  = 5000;
    localparam int startLimit = 100;
    localparam int freeLimit  = 200;
    localparam int drainLimit = 3000;

    logic               iClk;
    logic               rstN;
    logic               wr;
    logic               full;
    logic               txLine;
    logic               txIdle;
    uartTxPkg::txWord_t wrWord;

    // words written but not yet seen on the line
    uartTxPkg::txWord_t expQ[$];
    logic               comparing;
    logic               sawFull;
    integer             seed;

    uartTx dut0 (
        .iClk   (iClk),
        .rstN   (rstN),
        .wrWord (wrWord),
        .wr     (wr),
        .full   (full),
        .txLine (txLine),
        .txIdle (txIdle)
    );

    initial
    begin
        iClk = 1'b0;
        forever #50 iClk = ~iClk;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // start, data LSB first, even parity if enabled, stop
    function automatic logic [10:0] expectedFrame(input uartTxPkg::txWord_t w,
                                                  output int len);
        logic [10:0] bits;
        logic        par;
        bits = '1;
        par  = 1'b0;
        bits[0] = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            bits[i + 1] = w.data[i];
            par = par ^ w.data[i];
        end
        if (w.parityEn)
        begin
            bits[9] = par;
            len = 11;
        end
        else
        begin
            len = 10;
        end
        return bits;
    endfunction

    // called at edge plus drvDelay, returns there with wr low
    task automatic writeWord(input uartTxPkg::txWord_t w);
        int t;
        t = 0;
        while (full !== 1'b0)
        begin
            @(posedge iClk);
            #drvDelay;
            t++;
            if (t > freeLimit) reportFailure("timeout waiting for the FIFO to leave full");
        end
        wrWord = w;
        wr     = 1'b1;
        expQ.push_back(w);
        @(posedge iClk);
        #drvDelay;
        wr = 1'b0;
    endtask

    task automatic waitDrain();
        int t;
        t = 0;
        while (!(txIdle === 1'b1 && expQ.size() == 0 && !comparing))
        begin
            @(negedge iClk);
            t++;
            if (t > drainLimit) reportFailure("timeout waiting for the transmitter to drain");
        end
        @(posedge iClk);
        #drvDelay;
    endtask

    function automatic uartTxPkg::txWord_t randomWord(input logic forceParity);
        uartTxPkg::txWord_t w;
        logic [31:0]        rnd;
        rnd = $random(seed);
        w.data     = rnd[7:0];
        w.parityEn = forceParity | rnd[8];
        return w;
    endfunction

    always @(negedge iClk)
    begin
        if (rstN && full)
        begin
            sawFull = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // comparing process, samples mid-bit on falling clock edges
    // ----------------------------------------------------------------------
    initial
    begin : compareProc
        uartTxPkg::txWord_t w;
        logic [10:0]        expBits;
        logic [10:0]        gotBits;
        int                 len;
        int                 t;
        int                 frameNo;
        comparing = 1'b0;
        frameNo   = 0;
        forever
        begin
            // line must stay high while nothing is expected
            t = 0;
            while (expQ.size() == 0)
            begin
                @(negedge iClk);
                assert (txLine === 1'b1)
                else reportFailure($sformatf("Fail txLine expected %h got %h with no word queued",
                                             1'b1, txLine));
                t++;
                if (t > idleLimit) reportFailure("timeout waiting for a word to be written");
            end
            t = 0;
            while (txLine !== 1'b0)
            begin
                @(negedge iClk);
                t++;
                if (t > startLimit) reportFailure("timeout waiting for a start bit");
            end
            comparing = 1'b1;
            w = expQ.pop_front();
            expBits = expectedFrame(w, len);
            gotBits = '1;
            $display("frame %0d data %h parity %0b, serializer %s", frameNo, w.data,
                     w.parityEn, dut0.ser0.state.name());
            repeat (clksPerBit / 2) @(negedge iClk);
            for (int i = 0; i < len; i++)
            begin
                if (i > 0)
                begin
                    repeat (clksPerBit) @(negedge iClk);
                end
                gotBits[i] = txLine;
                assert (txLine === expBits[i])
                else reportFailure($sformatf("Fail txLine bit %0d expected frame %h sampled %h",
                                             i, expBits, gotBits));
            end
            frameNo++;
            comparing = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial
    begin : stimProc
        uartTxPkg::txWord_t w;
        int                 lat;
        seed    = 48;
        sawFull = 1'b0;
        rstN    = 1'b0;
        wr      = 1'b0;
        wrWord  = '0;

        // reset state, held for eight cycles then a few after release
        for (int i = 0; i < 11; i++)
        begin
            if (i == 8)
            begin
                @(posedge iClk);
                #drvDelay;
                rstN = 1'b1;
            end
            @(negedge iClk);
            assert (txLine === 1'b1 && full === 1'b0 && txIdle === 1'b1)
            else reportFailure($sformatf("Fail reset txLine %h full %h txIdle %h",
                                         txLine, full, txIdle));
        end
        @(posedge iClk);
        #drvDelay;

        // single frame without parity, start bit four cycles after the write
        w.data     = 8'hA5;
        w.parityEn = 1'b0;
        wrWord = w;
        wr     = 1'b1;
        expQ.push_back(w);
        @(posedge iClk);
        #drvDelay;
        wr  = 1'b0;
        lat = 0;
        do
        begin
            @(negedge iClk);
            lat++;
            if (lat > 20) reportFailure("timeout waiting for the first start bit");
        end
        while (txLine !== 1'b0);
        assert (lat == 4)
        else reportFailure($sformatf("Fail txLine start latency expected %h got %h", 4, lat));
        waitDrain();

        // parity frames, corner data then random data
        w.parityEn = 1'b1;
        w.data = 8'h00;
        writeWord(w);
        w.data = 8'hFF;
        writeWord(w);
        w.data = 8'h80;
        writeWord(w);
        for (int i = 0; i < 5; i++)
        begin
            writeWord(randomWord(1'b1));
        end
        waitDrain();

        // fill at full speed, the serializer holds the FIFO back
        for (int i = 0; i < 20; i++)
        begin
            writeWord(randomWord(1'b0));
        end
        waitDrain();
        assert (sawFull)
        else reportFailure("full never went high while filling the FIFO");

        // drained, line and idle level stay high
        repeat (20)
        begin
            @(negedge iClk);
            assert (txLine === 1'b1 && txIdle === 1'b1)
            else reportFailure($sformatf("Fail txIdle %h txLine %h after drain", txIdle, txLine));
        end
        @(posedge iClk);
        #drvDelay;
        writeWord(randomWord(1'b0));
        waitDrain();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== uartTx.f ====
+incdir+rtl
rtl/uartTxPkg.sv
rtl/fifoRam.sv
rtl/fifoController.sv
rtl/txScheduler.sv
rtl/txSerializer.sv
rtl/uartTx.sv
tests/uartTxTb.sv
